// File: hw/mipsIsaPkg.sv
package mipsIsaPkg;

  localparam int RegNumWidth = 5;
  localparam int OpcodeWidth = 6;
  localparam int FunctWidth  = 6;

  // Standard R/I field split with imm16 over rd/shamt/funct
  typedef struct packed {
    logic [OpcodeWidth-1:0] opcode;
    logic [RegNumWidth-1:0] rs;
    logic [RegNumWidth-1:0] rt;
    logic [RegNumWidth-1:0] rd;
    logic [RegNumWidth-1:0] shamt;
    logic [FunctWidth-1:0]  funct;
  } mipsInst;

  // Raw view for the immediate
  typedef union packed {
    mipsInst     fields;
    logic [31:0] raw;
  } mipsWordView;

  // Opcodes
  localparam logic [OpcodeWidth-1:0] OpSpecial = 6'b000000;
  localparam logic [OpcodeWidth-1:0] OpAddi    = 6'b001000;
  localparam logic [OpcodeWidth-1:0] OpAddiu   = 6'b001001;
  localparam logic [OpcodeWidth-1:0] OpAndi    = 6'b001100;
  localparam logic [OpcodeWidth-1:0] OpOri     = 6'b001101;
  localparam logic [OpcodeWidth-1:0] OpXori    = 6'b001110;
  localparam logic [OpcodeWidth-1:0] OpLb      = 6'b100000;
  localparam logic [OpcodeWidth-1:0] OpLh      = 6'b100001;
  localparam logic [OpcodeWidth-1:0] OpLw      = 6'b100011;
  localparam logic [OpcodeWidth-1:0] OpLbu     = 6'b100100;
  localparam logic [OpcodeWidth-1:0] OpLhu     = 6'b100101;
  localparam logic [OpcodeWidth-1:0] OpSb      = 6'b101000;
  localparam logic [OpcodeWidth-1:0] OpSh      = 6'b101001;
  localparam logic [OpcodeWidth-1:0] OpSw      = 6'b101011;

  // SPECIAL funct codes
  localparam logic [FunctWidth-1:0] FnSll  = 6'b000000;
  localparam logic [FunctWidth-1:0] FnSrl  = 6'b000010;
  localparam logic [FunctWidth-1:0] FnSra  = 6'b000011;
  localparam logic [FunctWidth-1:0] FnSllv = 6'b000100;
  localparam logic [FunctWidth-1:0] FnSrlv = 6'b000110;
  localparam logic [FunctWidth-1:0] FnSrav = 6'b000111;
  localparam logic [FunctWidth-1:0] FnMfhi = 6'b010000;
  localparam logic [FunctWidth-1:0] FnMthi = 6'b010001;
  localparam logic [FunctWidth-1:0] FnMflo = 6'b010010;
  localparam logic [FunctWidth-1:0] FnMtlo = 6'b010011;
  localparam logic [FunctWidth-1:0] FnAdd  = 6'b100000;
  localparam logic [FunctWidth-1:0] FnAddu = 6'b100001;
  localparam logic [FunctWidth-1:0] FnSub  = 6'b100010;
  localparam logic [FunctWidth-1:0] FnSubu = 6'b100011;
  localparam logic [FunctWidth-1:0] FnAnd  = 6'b100100;
  localparam logic [FunctWidth-1:0] FnOr   = 6'b100101;
  localparam logic [FunctWidth-1:0] FnXor  = 6'b100110;
  localparam logic [FunctWidth-1:0] FnNor  = 6'b100111;

endpackage

// File: hw/oiscPkg.sv
package oiscPkg;

  localparam int OiscAddrWidth = 16;
  localparam int StepWidth     = 3;

  typedef logic [OiscAddrWidth-1:0] oiscAddr;

  typedef struct packed {
    oiscAddr src;
    oiscAddr dst;
  } oiscWord;

  // GPR n lives at GprBase + n
  localparam oiscAddr GprBase = 16'h0100;

  localparam oiscAddr HiAddr  = 16'h0020;
  localparam oiscAddr LoAddr  = 16'h0021;
  localparam oiscAddr ImmAddr = 16'h0030; // Immediate staging register

  // Memory unit
  localparam oiscAddr MmuBase       = 16'h0040;
  localparam oiscAddr MmuOffset     = 16'h0041;
  localparam oiscAddr MmuAccessCtrl = 16'h0042;
  localparam oiscAddr MmuReadData   = 16'h0043;
  localparam oiscAddr MmuWriteData  = 16'h0044;

  // Function units
  localparam oiscAddr AndBase   = 16'h1000;
  localparam oiscAddr OrBase    = 16'h1010;
  localparam oiscAddr XorBase   = 16'h1020;
  localparam oiscAddr NorBase   = 16'h1030;
  localparam oiscAddr AddBase   = 16'h1040;
  localparam oiscAddr ShiftBase = 16'h1050;

  localparam oiscAddr AccOffset     = 16'd0;
  localparam oiscAddr OperandOffset = 16'd1;
  localparam oiscAddr CtrlOffset    = 16'd2;

  // Adder control with subtract in bit 1 and overflow trap in bit 0
  localparam oiscAddr CtrlAdd  = 16'b01;
  localparam oiscAddr CtrlAddu = 16'b00;
  localparam oiscAddr CtrlSub  = 16'b11;
  localparam oiscAddr CtrlSubu = 16'b10;

  // Shifter control with left in bit 1 and arithmetic in bit 0
  localparam oiscAddr CtrlSll = 16'b10;
  localparam oiscAddr CtrlSrl = 16'b00;
  localparam oiscAddr CtrlSra = 16'b01;

  // Access control as {left, aligned, signed, size[1:0]}
  localparam oiscAddr AccLb  = 16'b01100;
  localparam oiscAddr AccLbu = 16'b01000;
  localparam oiscAddr AccLh  = 16'b01101;
  localparam oiscAddr AccLhu = 16'b01001;
  localparam oiscAddr AccLw  = 16'b01010;
  localparam oiscAddr AccSb  = 16'b01100;
  localparam oiscAddr AccSh  = 16'b01101;
  localparam oiscAddr AccSw  = 16'b01110;

  typedef enum logic [2:0] {
    KindIllegal,
    KindLogic3R,
    KindLogic2I,
    KindCtrl3R,
    KindCtrl2I,
    KindMove,
    KindMemRead,
    KindMemWrite
  } instKind;

  function automatic logic [StepWidth-1:0] stepCount(input instKind kind);
    case (kind)
      KindLogic3R:  return 3'd3;
      KindLogic2I:  return 3'd4;
      KindCtrl3R:   return 3'd4;
      KindCtrl2I:   return 3'd5;
      KindMove:     return 3'd1;
      KindMemRead:  return 3'd4;
      KindMemWrite: return 3'd4;
      default:      return 3'd0;
    endcase
  endfunction

  typedef struct packed {
    instKind kind;
    oiscAddr unitBase;
    oiscAddr ctrl;     // Zero-extended unit or access code
    oiscAddr srcAddr;
    oiscAddr opBAddr;
    oiscAddr dstAddr;
    logic [OiscAddrWidth-1:0] imm;
    oiscAddr moveSrc;
    oiscAddr moveDst;
  } decodedInst;

endpackage

// File: hw/instDecoder.sv
`timescale 1ns/1ps

module instDecoder (
  input  mipsIsaPkg::mipsInst Inst,
  output oiscPkg::decodedInst Decoded
);

  typedef struct packed {
    oiscPkg::instKind kind;
    oiscPkg::oiscAddr base;
    oiscPkg::oiscAddr ctrl;
  } tableEntry;

  mipsIsaPkg::mipsWordView view;
  tableEntry e;
  oiscPkg::decodedInst routed;
  oiscPkg::oiscAddr rsAddr;
  oiscPkg::oiscAddr rtAddr;
  oiscPkg::oiscAddr rdAddr;
  oiscPkg::oiscAddr imm16;
  oiscPkg::oiscAddr shamtExt;
  logic onShifter;
  logic shiftFn;
  logic shamtBad;

  function automatic oiscPkg::oiscAddr gprAddr(input logic [mipsIsaPkg::RegNumWidth-1:0] r);
    return oiscPkg::GprBase + oiscPkg::oiscAddr'(r);
  endfunction

  assign view     = Inst;
  assign rsAddr   = gprAddr(view.fields.rs);
  assign rtAddr   = gprAddr(view.fields.rt);
  assign rdAddr   = gprAddr(view.fields.rd);
  assign imm16    = view.raw[15:0];
  assign shamtExt = oiscPkg::oiscAddr'(view.fields.shamt);

  assign shiftFn = view.fields.funct inside {mipsIsaPkg::FnSll, mipsIsaPkg::FnSrl,
      mipsIsaPkg::FnSra, mipsIsaPkg::FnSllv, mipsIsaPkg::FnSrlv, mipsIsaPkg::FnSrav};
  assign shamtBad = (view.fields.opcode == mipsIsaPkg::OpSpecial) && !shiftFn &&
                    (view.fields.shamt != '0);

  // Table of kind, unit and control code with HI/LO as base for moves
  always_comb begin
    e = '{oiscPkg::KindIllegal, '0, '0};
    case (view.fields.opcode)
      mipsIsaPkg::OpSpecial: begin
        case (view.fields.funct)
          mipsIsaPkg::FnAnd:  e = '{oiscPkg::KindLogic3R, oiscPkg::AndBase, '0};
          mipsIsaPkg::FnOr:   e = '{oiscPkg::KindLogic3R, oiscPkg::OrBase, '0};
          mipsIsaPkg::FnXor:  e = '{oiscPkg::KindLogic3R, oiscPkg::XorBase, '0};
          mipsIsaPkg::FnNor:  e = '{oiscPkg::KindLogic3R, oiscPkg::NorBase, '0};
          mipsIsaPkg::FnAdd:  e = '{oiscPkg::KindCtrl3R, oiscPkg::AddBase, oiscPkg::CtrlAdd};
          mipsIsaPkg::FnAddu: e = '{oiscPkg::KindCtrl3R, oiscPkg::AddBase, oiscPkg::CtrlAddu};
          mipsIsaPkg::FnSub:  e = '{oiscPkg::KindCtrl3R, oiscPkg::AddBase, oiscPkg::CtrlSub};
          mipsIsaPkg::FnSubu: e = '{oiscPkg::KindCtrl3R, oiscPkg::AddBase, oiscPkg::CtrlSubu};
          mipsIsaPkg::FnSllv: e = '{oiscPkg::KindCtrl3R, oiscPkg::ShiftBase, oiscPkg::CtrlSll};
          mipsIsaPkg::FnSrlv: e = '{oiscPkg::KindCtrl3R, oiscPkg::ShiftBase, oiscPkg::CtrlSrl};
          mipsIsaPkg::FnSrav: e = '{oiscPkg::KindCtrl3R, oiscPkg::ShiftBase, oiscPkg::CtrlSra};
          mipsIsaPkg::FnSll:  e = '{oiscPkg::KindCtrl2I, oiscPkg::ShiftBase, oiscPkg::CtrlSll};
          mipsIsaPkg::FnSrl:  e = '{oiscPkg::KindCtrl2I, oiscPkg::ShiftBase, oiscPkg::CtrlSrl};
          mipsIsaPkg::FnSra:  e = '{oiscPkg::KindCtrl2I, oiscPkg::ShiftBase, oiscPkg::CtrlSra};
          mipsIsaPkg::FnMfhi: e = '{oiscPkg::KindMove, oiscPkg::HiAddr, '0};
          mipsIsaPkg::FnMthi: e = '{oiscPkg::KindMove, oiscPkg::HiAddr, '0};
          mipsIsaPkg::FnMflo: e = '{oiscPkg::KindMove, oiscPkg::LoAddr, '0};
          mipsIsaPkg::FnMtlo: e = '{oiscPkg::KindMove, oiscPkg::LoAddr, '0};
          default: ;
        endcase
      end
      mipsIsaPkg::OpAndi:  e = '{oiscPkg::KindLogic2I, oiscPkg::AndBase, '0};
      mipsIsaPkg::OpOri:   e = '{oiscPkg::KindLogic2I, oiscPkg::OrBase, '0};
      mipsIsaPkg::OpXori:  e = '{oiscPkg::KindLogic2I, oiscPkg::XorBase, '0};
      mipsIsaPkg::OpAddi:  e = '{oiscPkg::KindCtrl2I, oiscPkg::AddBase, oiscPkg::CtrlAdd};
      mipsIsaPkg::OpAddiu: e = '{oiscPkg::KindCtrl2I, oiscPkg::AddBase, oiscPkg::CtrlAddu};
      mipsIsaPkg::OpLb:    e = '{oiscPkg::KindMemRead, oiscPkg::MmuBase, oiscPkg::AccLb};
      mipsIsaPkg::OpLbu:   e = '{oiscPkg::KindMemRead, oiscPkg::MmuBase, oiscPkg::AccLbu};
      mipsIsaPkg::OpLh:    e = '{oiscPkg::KindMemRead, oiscPkg::MmuBase, oiscPkg::AccLh};
      mipsIsaPkg::OpLhu:   e = '{oiscPkg::KindMemRead, oiscPkg::MmuBase, oiscPkg::AccLhu};
      mipsIsaPkg::OpLw:    e = '{oiscPkg::KindMemRead, oiscPkg::MmuBase, oiscPkg::AccLw};
      mipsIsaPkg::OpSb:    e = '{oiscPkg::KindMemWrite, oiscPkg::MmuBase, oiscPkg::AccSb};
      mipsIsaPkg::OpSh:    e = '{oiscPkg::KindMemWrite, oiscPkg::MmuBase, oiscPkg::AccSh};
      mipsIsaPkg::OpSw:    e = '{oiscPkg::KindMemWrite, oiscPkg::MmuBase, oiscPkg::AccSw};
      default: ;
    endcase
  end

  assign onShifter = (e.base == oiscPkg::ShiftBase);

  // Operand routing by kind
  always_comb begin
    routed          = '0;
    routed.kind     = e.kind;
    routed.unitBase = e.base;
    routed.ctrl     = e.ctrl;
    case (e.kind)
      oiscPkg::KindLogic3R, oiscPkg::KindCtrl3R: begin
        routed.srcAddr = onShifter ? rtAddr : rsAddr; // Variable shift takes its value from rt
        routed.opBAddr = onShifter ? rsAddr : rtAddr;
        routed.dstAddr = rdAddr;
      end
      oiscPkg::KindLogic2I, oiscPkg::KindCtrl2I: begin
        routed.srcAddr = onShifter ? rtAddr : rsAddr;
        routed.imm     = onShifter ? shamtExt : imm16;
        routed.dstAddr = onShifter ? rdAddr : rtAddr;
      end
      oiscPkg::KindMemRead, oiscPkg::KindMemWrite: begin
        routed.srcAddr = rsAddr;
        routed.imm     = imm16;
        routed.opBAddr = rtAddr; // Store data
        routed.dstAddr = rtAddr; // Load target
      end
      oiscPkg::KindMove: begin
        // MTxx has funct bit 0 set
        routed.moveSrc = view.fields.funct[0] ? rsAddr : e.base;
        routed.moveDst = view.fields.funct[0] ? e.base : rdAddr;
      end
      default: ;
    endcase
  end

  assign Decoded = shamtBad ? oiscPkg::decodedInst'('0) : routed;

endmodule

// File: hw/stepSequencer.sv
`timescale 1ns/1ps

module stepSequencer (
  input  logic                          CLK,
  input  logic                          RST,
  input  logic                          InValid,
  output logic                          InReady,
  input  oiscPkg::decodedInst           Decoded,
  output logic                          OutValid,
  input  logic                          OutReady,
  output oiscPkg::decodedInst           Held,
  output logic [oiscPkg::StepWidth-1:0] Step,
  output logic                          IllegalInst
);

  logic busy;
  logic accept;
  logic xfer;
  logic lastXfer;
  logic [oiscPkg::StepWidth-1:0] lastStep;

  assign InReady  = !busy;
  assign OutValid = busy;

  assign accept   = InValid && InReady;
  assign xfer     = OutValid && OutReady;
  assign lastStep = oiscPkg::stepCount(Held.kind) - 1'b1;
  assign lastXfer = xfer && (Step == lastStep);

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      busy        <= 1'b0;
      Step        <= '0;
      IllegalInst <= 1'b0;
    end else begin
      IllegalInst <= accept && (Decoded.kind == oiscPkg::KindIllegal); // One-cycle pulse
      if (accept) begin
        busy <= (Decoded.kind != oiscPkg::KindIllegal);
        Step <= '0;
      end else if (xfer) begin
        Step <= Step + 1'b1;
        if (lastXfer)
          busy <= 1'b0; // Hand back to the input side
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (accept)
      Held <= Decoded;
  end

  assert property (@(posedge CLK) disable iff (RST)
      busy |-> (Held.kind != oiscPkg::KindIllegal) && (Step < oiscPkg::stepCount(Held.kind)))
    else $error("stepSequencer: step %0d out of range for kind %s", Step, Held.kind.name());

  // Output word must hold under back-pressure
  assert property (@(posedge CLK) disable iff (RST)
      OutValid && !OutReady |=> $stable(Held) && $stable(Step))
    else $error("stepSequencer: instruction or step changed while stalled");

endmodule

// File: hw/wordComposer.sv
`timescale 1ns/1ps

module wordComposer (
  input  oiscPkg::decodedInst           Held,
  input  logic [oiscPkg::StepWidth-1:0] Step,
  output oiscPkg::oiscWord              Word
);

  oiscPkg::oiscAddr accAddr;
  oiscPkg::oiscAddr opAddr;
  oiscPkg::oiscAddr ctrlAddr;
  logic hasCtrl;

  function automatic oiscPkg::oiscWord mv(input oiscPkg::oiscAddr src, dst);
    oiscPkg::oiscWord w;
    w.src = src;
    w.dst = dst;
    return w;
  endfunction

  assign accAddr  = Held.unitBase + oiscPkg::AccOffset;
  assign opAddr   = Held.unitBase + oiscPkg::OperandOffset;
  assign ctrlAddr = Held.unitBase + oiscPkg::CtrlOffset;
  assign hasCtrl  = (Held.kind == oiscPkg::KindCtrl3R) || (Held.kind == oiscPkg::KindCtrl2I);

  always_comb begin
    Word = '0;
    case (Held.kind)
      oiscPkg::KindLogic3R, oiscPkg::KindCtrl3R: begin
        case (Step)
          3'd0: Word = mv(Held.srcAddr, accAddr);
          3'd1: Word = mv(Held.opBAddr, opAddr);
          3'd2: Word = hasCtrl ? mv(Held.ctrl, ctrlAddr) : mv(accAddr, Held.dstAddr);
          3'd3: Word = mv(accAddr, Held.dstAddr);
          default: ;
        endcase
      end
      oiscPkg::KindLogic2I, oiscPkg::KindCtrl2I: begin
        case (Step)
          3'd0: Word = mv(Held.srcAddr, accAddr);
          3'd1: Word = mv(Held.imm, oiscPkg::ImmAddr); // Stage immediate
          3'd2: Word = mv(oiscPkg::ImmAddr, opAddr);
          3'd3: Word = hasCtrl ? mv(Held.ctrl, ctrlAddr) : mv(accAddr, Held.dstAddr);
          3'd4: Word = mv(accAddr, Held.dstAddr);
          default: ;
        endcase
      end
      oiscPkg::KindMemRead, oiscPkg::KindMemWrite: begin
        case (Step)
          3'd0: Word = mv(Held.srcAddr, oiscPkg::MmuBase);
          3'd1: Word = mv(Held.imm, oiscPkg::MmuOffset);
          3'd2: Word = mv(Held.ctrl, oiscPkg::MmuAccessCtrl);
          3'd3: Word = (Held.kind == oiscPkg::KindMemRead) ?
                       mv(oiscPkg::MmuReadData, Held.dstAddr) :
                       mv(Held.opBAddr, oiscPkg::MmuWriteData);
          default: ;
        endcase
      end
      oiscPkg::KindMove: Word = mv(Held.moveSrc, Held.moveDst);
      default: ;
    endcase
  end

endmodule

// File: hw/mips2Oisc.sv
`timescale 1ns/1ps

module mips2Oisc (
  input  logic                CLK,
  input  logic                RST,
  input  logic                InstructionInValid,
  output logic                InstructionInReady,
  input  mipsIsaPkg::mipsInst InstructionInData,
  output logic                InstructionOutValid,
  input  logic                InstructionOutReady,
  output oiscPkg::oiscWord    InstructionOutData,
  output logic                IllegalInst
);

  oiscPkg::decodedInst decoded;
  oiscPkg::decodedInst held;
  logic [oiscPkg::StepWidth-1:0] step;

  instDecoder u_instDecoder (
    .Inst    (InstructionInData),
    .Decoded (decoded)
  );

  stepSequencer u_stepSequencer (
    .CLK         (CLK),
    .RST         (RST),
    .InValid     (InstructionInValid),
    .InReady     (InstructionInReady),
    .Decoded     (decoded),
    .OutValid    (InstructionOutValid),
    .OutReady    (InstructionOutReady),
    .Held        (held),
    .Step        (step),
    .IllegalInst (IllegalInst)
  );

  wordComposer u_wordComposer (
    .Held (held),
    .Step (step),
    .Word (InstructionOutData)
  );

endmodule

// File: verif/oiscExpect.svh
localparam logic [15:0] ExpGprBase = 16'h0100;
localparam logic [15:0] ExpImmAddr = 16'h0030;

logic [31:0] expWords [0:7];
int expCount;

function automatic void pushMove(input logic [15:0] src, input logic [15:0] dst);
  expWords[expCount] = {src, dst};
  expCount++;
endfunction

// Acc and operand B from registers, then optional control and the result
function automatic void regOp(input logic [15:0] unit, input bit hasCtrl, input logic [15:0] code,
                              input logic [15:0] a, input logic [15:0] b, input logic [15:0] d);
  pushMove(a, unit);
  pushMove(b, unit + 16'd1);
  if (hasCtrl)
    pushMove(code, unit + 16'd2);
  pushMove(unit, d);
endfunction

// Immediate goes through the staging register
function automatic void immOp(input logic [15:0] unit, input bit hasCtrl, input logic [15:0] code,
                              input logic [15:0] a, input logic [15:0] imm, input logic [15:0] d);
  pushMove(a, unit);
  pushMove(imm, ExpImmAddr);
  pushMove(ExpImmAddr, unit + 16'd1);
  if (hasCtrl)
    pushMove(code, unit + 16'd2);
  pushMove(unit, d);
endfunction

function automatic void memOp(input logic [15:0] base, input logic [15:0] offset,
                              input logic [15:0] code, input logic [15:0] src,
                              input logic [15:0] dst);
  pushMove(base, 16'h0040);
  pushMove(offset, 16'h0041);
  pushMove(code, 16'h0042);
  pushMove(src, dst); // Read data out or write data in
endfunction

// Fills expWords and returns the word count
function automatic int oiscExpect(input logic [31:0] inst);
  logic [15:0] rs;
  logic [15:0] rt;
  logic [15:0] rd;
  logic [15:0] imm;
  logic [15:0] sa;
  rs  = ExpGprBase + inst[25:21];
  rt  = ExpGprBase + inst[20:16];
  rd  = ExpGprBase + inst[15:11];
  imm = inst[15:0];
  sa  = {11'd0, inst[10:6]};
  expCount = 0;
  if (inst[31:26] == 6'h00) begin
    // Only shift functs may carry a nonzero shamt
    if (inst[10:6] != 5'd0 && inst[5:3] != 3'b000)
      return 0;
    case (inst[5:0])
      6'h24: regOp(16'h1000, 1'b0, 16'h0, rs, rt, rd);
      6'h25: regOp(16'h1010, 1'b0, 16'h0, rs, rt, rd);
      6'h26: regOp(16'h1020, 1'b0, 16'h0, rs, rt, rd);
      6'h27: regOp(16'h1030, 1'b0, 16'h0, rs, rt, rd);
      6'h20: regOp(16'h1040, 1'b1, 16'h1, rs, rt, rd);
      6'h21: regOp(16'h1040, 1'b1, 16'h0, rs, rt, rd);
      6'h22: regOp(16'h1040, 1'b1, 16'h3, rs, rt, rd);
      6'h23: regOp(16'h1040, 1'b1, 16'h2, rs, rt, rd);
      6'h04: regOp(16'h1050, 1'b1, 16'h2, rt, rs, rd); // Value rt, amount rs
      6'h06: regOp(16'h1050, 1'b1, 16'h0, rt, rs, rd);
      6'h07: regOp(16'h1050, 1'b1, 16'h1, rt, rs, rd);
      6'h00: immOp(16'h1050, 1'b1, 16'h2, rt, sa, rd);
      6'h02: immOp(16'h1050, 1'b1, 16'h0, rt, sa, rd);
      6'h03: immOp(16'h1050, 1'b1, 16'h1, rt, sa, rd);
      6'h10: pushMove(16'h0020, rd);
      6'h12: pushMove(16'h0021, rd);
      6'h11: pushMove(rs, 16'h0020);
      6'h13: pushMove(rs, 16'h0021);
      default: ;
    endcase
  end else begin
    case (inst[31:26])
      6'h0c: immOp(16'h1000, 1'b0, 16'h0, rs, imm, rt);
      6'h0d: immOp(16'h1010, 1'b0, 16'h0, rs, imm, rt);
      6'h0e: immOp(16'h1020, 1'b0, 16'h0, rs, imm, rt);
      6'h08: immOp(16'h1040, 1'b1, 16'h1, rs, imm, rt);
      6'h09: immOp(16'h1040, 1'b1, 16'h0, rs, imm, rt);
      6'h20: memOp(rs, imm, 16'h0c, 16'h0043, rt);
      6'h24: memOp(rs, imm, 16'h08, 16'h0043, rt);
      6'h21: memOp(rs, imm, 16'h0d, 16'h0043, rt);
      6'h25: memOp(rs, imm, 16'h09, 16'h0043, rt);
      6'h23: memOp(rs, imm, 16'h0a, 16'h0043, rt);
      6'h28: memOp(rs, imm, 16'h0c, rt, 16'h0044);
      6'h29: memOp(rs, imm, 16'h0d, rt, 16'h0044);
      6'h2b: memOp(rs, imm, 16'h0e, rt, 16'h0044);
      default: ;
    endcase
  end
  return expCount;
endfunction

// File: verif/mips2OiscTb.sv
`timescale 1ns/1ps

module mips2OiscTb;

  // About 40 instructions, up to 5 words, up to 10 stall cycles each, plus margin
  localparam int TimeoutCycles = 40 * 5 * 10 + 1000;
  localparam int IdleLimit     = 20;

  logic CLK;
  logic RST;
  logic inValid;
  logic inReady;
  mipsIsaPkg::mipsInst inData;
  logic outValid;
  logic outReady;
  oiscPkg::oiscWord outData;
  logic illegal;

  int cycles = 0;
  int passCount = 0;
  int failCount = 0;
  int testErrors;
  logic [31:0] gotWords [0:15];
  int gotCount;

  `include "oiscExpect.svh"

  mips2Oisc u_mips2Oisc (
    .CLK                 (CLK),
    .RST                 (RST),
    .InstructionInValid  (inValid),
    .InstructionInReady  (inReady),
    .InstructionInData   (inData),
    .InstructionOutValid (outValid),
    .InstructionOutReady (outReady),
    .InstructionOutData  (outData),
    .IllegalInst         (illegal)
  );

  initial begin
    CLK = 1'b0;
    forever #2 CLK = ~CLK;
  end

  always @(posedge CLK) begin
    cycles++;
    if (cycles > TimeoutCycles) begin
      $display("Run stopped after %0d cycles without finishing the tests", cycles);
      $display("TEST RESULT: FAIL");
      $finish;
    end
  end

  function automatic logic [4:0] randReg();
    logic [4:0] r;
    r = $urandom % 32;
    return r;
  endfunction

  function automatic logic [15:0] randImm();
    logic [15:0] v;
    v = $urandom % 65536;
    return v;
  endfunction

  function automatic logic [31:0] rType(input logic [4:0] rs, input logic [4:0] rt,
                                        input logic [4:0] rd, input logic [4:0] sa,
                                        input logic [5:0] fn);
    return {6'h00, rs, rt, rd, sa, fn};
  endfunction

  function automatic logic [31:0] iType(input logic [5:0] op, input logic [4:0] rs,
                                        input logic [4:0] rt, input logic [15:0] imm);
    return {op, rs, rt, imm};
  endfunction

  // Holds valid and data until the accepting edge
  task automatic sendInst(input logic [31:0] word);
    inValid = 1'b1;
    inData  = word;
    while (!inReady) begin
      @(posedge CLK);
      #1;
    end
    @(posedge CLK);
    #1;
    inValid = 1'b0;
  endtask

  task automatic collectWords(input int expected, input bit randomReady, input string name);
    int idle;
    int elapsed;
    gotCount = 0;
    idle     = 0;
    elapsed  = 0;
    while (gotCount < expected && idle < IdleLimit) begin
      outReady = randomReady ? (($urandom % 2) == 1) : 1'b1;
      if (inReady) begin
        $display("%s: input ready before the last word was transferred", name);
        testErrors++;
      end
      if (illegal) begin
        $display("%s: IllegalInst raised for a legal instruction", name);
        testErrors++;
      end
      if (outValid && outReady) begin
        gotWords[gotCount] = outData; // Transfers at the next edge
        gotCount++;
      end
      if (!outValid)
        idle++;
      elapsed++;
      @(posedge CLK);
      #1;
    end
    outReady = 1'b0;
    if (!randomReady && gotCount == expected && elapsed != expected) begin
      $display("Error %s: cycles for %0d words expected %0d actual %0d",
               name, expected, expected, elapsed);
      testErrors++;
    end
  endtask

  task automatic runInst(input string name, input logic [31:0] word, input bit randomReady);
    int n;
    int i;
    n = oiscExpect(word);
    sendInst(word);
    collectWords(n, randomReady, name);
    if (gotCount != n) begin
      $display("%s: only %0d of %0d words came out for %h", name, gotCount, n, word);
      testErrors++;
    end
    for (i = 0; i < gotCount; i++) begin
      if (gotWords[i] !== expWords[i]) begin
        $display("Error %s: word %0d of %h expected %h actual %h",
                 name, i, word, expWords[i], gotWords[i]);
        testErrors++;
      end
    end
    if (outValid) begin
      $display("%s: extra word after the sequence of %h", name, word);
      testErrors++;
    end
    if (!inReady) begin
      $display("%s: input not ready after the last word of %h", name, word);
      testErrors++;
    end
  endtask

  task automatic finishTest(input string name);
    if (testErrors == 0) begin
      passCount++;
      $display("%s: passed", name);
    end else begin
      failCount++;
      $display("%s: failed with %0d errors", name, testErrors);
    end
  endtask

  task automatic resetState();
    testErrors = 0;
    if (inReady !== 1'b1) begin
      $display("Error resetState: InstructionInReady expected 1 actual %b", inReady);
      testErrors++;
    end
    if (outValid !== 1'b0) begin
      $display("Error resetState: InstructionOutValid expected 0 actual %b", outValid);
      testErrors++;
    end
    if (illegal !== 1'b0) begin
      $display("Error resetState: IllegalInst expected 0 actual %b", illegal);
      testErrors++;
    end
    finishTest("resetState");
  endtask

  task automatic logicOps();
    testErrors = 0;
    runInst("logicOps", rType(randReg(), randReg(), randReg(), 5'd0, 6'h24), 1'b0);
    runInst("logicOps", rType(randReg(), randReg(), randReg(), 5'd0, 6'h25), 1'b0);
    runInst("logicOps", rType(randReg(), randReg(), randReg(), 5'd0, 6'h26), 1'b0);
    runInst("logicOps", rType(randReg(), randReg(), randReg(), 5'd0, 6'h27), 1'b0);
    runInst("logicOps", iType(6'h0c, randReg(), randReg(), randImm()), 1'b0);
    runInst("logicOps", iType(6'h0d, randReg(), randReg(), randImm()), 1'b0);
    runInst("logicOps", iType(6'h0e, randReg(), randReg(), randImm()), 1'b0);
    finishTest("logicOps");
  endtask

  task automatic arithShiftOps();
    testErrors = 0;
    runInst("arithShiftOps", rType(randReg(), randReg(), randReg(), 5'd0, 6'h20), 1'b0);
    runInst("arithShiftOps", rType(randReg(), randReg(), randReg(), 5'd0, 6'h21), 1'b0);
    runInst("arithShiftOps", rType(randReg(), randReg(), randReg(), 5'd0, 6'h22), 1'b0);
    runInst("arithShiftOps", rType(randReg(), randReg(), randReg(), 5'd0, 6'h23), 1'b0);
    runInst("arithShiftOps", rType(randReg(), randReg(), randReg(), 5'd0, 6'h04), 1'b0);
    runInst("arithShiftOps", rType(randReg(), randReg(), randReg(), 5'd0, 6'h06), 1'b0);
    runInst("arithShiftOps", rType(randReg(), randReg(), randReg(), 5'd0, 6'h07), 1'b0);
    runInst("arithShiftOps", iType(6'h08, randReg(), randReg(), randImm()), 1'b0);
    runInst("arithShiftOps", iType(6'h09, randReg(), randReg(), randImm()), 1'b0);
    runInst("arithShiftOps", rType(5'd0, randReg(), randReg(), randReg(), 6'h00), 1'b0);
    runInst("arithShiftOps", rType(5'd0, randReg(), randReg(), randReg(), 6'h02), 1'b0);
    runInst("arithShiftOps", rType(5'd0, randReg(), randReg(), randReg(), 6'h03), 1'b0);
    finishTest("arithShiftOps");
  endtask

  task automatic memMoveOps();
    testErrors = 0;
    runInst("memMoveOps", iType(6'h20, randReg(), randReg(), randImm()), 1'b0);
    runInst("memMoveOps", iType(6'h24, randReg(), randReg(), randImm()), 1'b0);
    runInst("memMoveOps", iType(6'h21, randReg(), randReg(), randImm()), 1'b0);
    runInst("memMoveOps", iType(6'h25, randReg(), randReg(), randImm()), 1'b0);
    runInst("memMoveOps", iType(6'h23, randReg(), randReg(), randImm()), 1'b0);
    runInst("memMoveOps", iType(6'h28, randReg(), randReg(), randImm()), 1'b0);
    runInst("memMoveOps", iType(6'h29, randReg(), randReg(), randImm()), 1'b0);
    runInst("memMoveOps", iType(6'h2b, randReg(), randReg(), randImm()), 1'b0);
    runInst("memMoveOps", rType(5'd0, 5'd0, randReg(), 5'd0, 6'h10), 1'b0); // MFHI
    runInst("memMoveOps", rType(5'd0, 5'd0, randReg(), 5'd0, 6'h12), 1'b0);
    runInst("memMoveOps", rType(randReg(), 5'd0, 5'd0, 5'd0, 6'h11), 1'b0); // MTHI
    runInst("memMoveOps", rType(randReg(), 5'd0, 5'd0, 5'd0, 6'h13), 1'b0);
    finishTest("memMoveOps");
  endtask

  task automatic backPressure();
    int i;
    testErrors = 0;
    for (i = 0; i < 2; i++) begin
      runInst("backPressure", iType(6'h08, randReg(), randReg(), randImm()), 1'b1);
      runInst("backPressure", rType(5'd0, randReg(), randReg(), randReg(), 6'h03), 1'b1);
      runInst("backPressure", iType(6'h2b, randReg(), randReg(), randImm()), 1'b1);
      runInst("backPressure", rType(randReg(), randReg(), randReg(), 5'd0, 6'h24), 1'b1);
      runInst("backPressure", rType(randReg(), 5'd0, 5'd0, 5'd0, 6'h13), 1'b1);
    end
    finishTest("backPressure");
  endtask

  // Expects one IllegalInst pulse right after acceptance and no output
  task automatic checkIllegal(input logic [31:0] word);
    int pulses;
    int i;
    pulses = 0;
    sendInst(word);
    for (i = 0; i < 4; i++) begin
      if (illegal)
        pulses++;
      if (illegal && i != 0) begin
        $display("illegalInst: IllegalInst high %0d cycles after accepting %h", i, word);
        testErrors++;
      end
      if (outValid || !inReady) begin
        $display("illegalInst: DUT went busy after illegal word %h", word);
        testErrors++;
      end
      @(posedge CLK);
      #1;
    end
    if (pulses != 1) begin
      $display("Error illegalInst: pulses for %h expected 1 actual %0d", word, pulses);
      testErrors++;
    end
  endtask

  task automatic illegalInst();
    testErrors = 0;
    checkIllegal(iType(6'h04, randReg(), randReg(), randImm())); // BEQ
    checkIllegal(rType(5'd0, 5'd0, 5'd0, 5'd0, 6'h0c));          // SYSCALL
    runInst("illegalInst", rType(randReg(), randReg(), randReg(), 5'd0, 6'h24), 1'b0);
    finishTest("illegalInst");
  endtask

  initial begin
    void'($urandom(32'h085c_a256));
    RST      = 1'b1;
    inValid  = 1'b0;
    inData   = '0;
    outReady = 1'b0;
    repeat (4) @(posedge CLK);
    #1;
    RST = 1'b0;
    resetState();
    logicOps();
    arithShiftOps();
    memMoveOps();
    backPressure();
    illegalInst();
    $display("Tests passed %0d, failed %0d", passCount, failCount);
    if (failCount == 0)
      $display("TEST RESULT: PASS");
    else
      $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

// File: mips2Oisc.f
+incdir+verif
hw/mipsIsaPkg.sv
hw/oiscPkg.sv
hw/instDecoder.sv
hw/stepSequencer.sv
hw/wordComposer.sv
hw/mips2Oisc.sv
verif/mips2OiscTb.sv
